//--- isqrtPkg.sv
package isqrtPkg;

  // A vector component is a signed two's complement number.
  localparam int compW = 24;

  // The radicand holds the sum of two squares, so it needs twice the component width.
  localparam int radW = 2 * compW;

  // The root of a radW-bit radicand fits in half as many bits.
  localparam int rootW = radW / 2;

  // Each pipeline stage resolves two root bits.
  localparam int numStages = rootW / 2;

  typedef logic signed [compW-1:0] compT;   // One vector component.
  typedef logic        [radW-1:0]  radT;    // Radicand, also a partial square.
  typedef logic        [rootW-1:0] rootT;   // Root, complete or partial.

  // One item as it moves between the front end and the root stages.
  // The partial fields start at zero and grow as bits are resolved.
  // sq always equals root * root, which lets each stage form its trial
  // square with an add instead of a multiply.
  typedef struct packed {
    logic valid;                            // Item present in this slot.
    radT  rad;                              // Radicand carried along unchanged.
    radT  sq;                               // Square of the partial root.
    rootT root;                             // Partial root, high bits first.
  } stageBusT;

endpackage

//--- sumSquares.sv
`timescale 1ns/100ps

module sumSquares (
  input  logic               clk,
  input  logic               arstN,
  input  logic               en,
  input  logic               inValid,
  input  isqrtPkg::compT     inX,
  input  isqrtPkg::compT     inY,
  output isqrtPkg::stageBusT busOut
);

  import isqrtPkg::*;

  // The products are formed at radicand width. Both operands are signed,
  // so the size cast sign-extends them before the multiply.
  logic signed [radW-1:0] sqX;
  logic signed [radW-1:0] sqY;
  radT                    radSum;
  stageBusT               frontBus;

  assign sqX = radW'(inX) * radW'(inX);
  assign sqY = radW'(inY) * radW'(inY);

  // Each square is at most 2**46, so the sum stays below 2**48 and has no carry out.
  // Both squares are non-negative, so reading them as unsigned loses nothing.
  assign radSum = radT'(sqX) + radT'(sqY);

  // The first root stage starts from an empty root and a zero square.
  always_comb begin
    frontBus       = '0;
    frontBus.valid = inValid;
    frontBus.rad   = radSum;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busOut <= '0;
    end else if (en) begin
      busOut <= frontBus;                   // Holds the item while the pipe is stalled.
    end
  end

endmodule

//--- isqrtStage.sv
`timescale 1ns/100ps

module isqrtStage #(
  parameter int stageIdx = 0
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               en,
  input  isqrtPkg::stageBusT busIn,
  output isqrtPkg::stageBusT busOut
);

  import isqrtPkg::*;

  // Stage 0 owns the top two root bits, the last stage owns bits 1 and 0.
  localparam int hiBit = rootW - 1 - 2 * stageIdx;
  localparam int loBit = hiBit - 1;

  stageBusT midBus;
  stageBusT nextBus;

  // Restoring step for root bit b.
  // Setting bit b turns root r into r + 2**b, and its square into
  // r*r + 2**(2b) + r * 2**(b+1). The bit is kept only if that square does
  // not pass the radicand. Bits below b are still zero here, so the trial
  // root never exceeds 2**24 - 1 and the trial square stays inside 48 bits.
  function automatic stageBusT tryBit(input stageBusT cur, input int b);
    stageBusT res;
    radT      trialSq;
    res     = cur;
    trialSq = cur.sq + (radT'(1) << (2 * b)) + (radT'(cur.root) << (b + 1));
    if (trialSq <= cur.rad) begin
      res.sq      = trialSq;
      res.root[b] = 1'b1;
    end
    return res;
  endfunction

  // The two steps chain, the low bit sees the result of the high bit.
  always_comb begin
    midBus  = tryBit(busIn, hiBit);
    nextBus = tryBit(midBus, loBit);
  end

  // The valid bit and radicand ride through unchanged with the partial result.
  // Every field is held when en is low, so a stall loses nothing.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busOut <= '0;
    end else if (en) begin
      busOut <= nextBus;
    end
  end

endmodule

//--- isqrtPipe.sv
`timescale 1ns/100ps

module isqrtPipe (
  input  logic               clk,
  input  logic               arstN,
  input  isqrtPkg::stageBusT busIn,
  output logic               en,
  output logic               outValid,
  output isqrtPkg::rootT     outMag,
  input  logic               outReady
);

  import isqrtPkg::*;

  // Entry k feeds stage k, the last entry is the finished item.
  stageBusT stageBus [numStages + 1];

  assign stageBus[0] = busIn;

  // The whole pipe advances together.
  // It only has to stop when a result waits at the output and the consumer
  // refuses it. An empty output slot can always take the next item, so
  // bubbles are squeezed out even while the consumer is stalled.
  assign en = !outValid || outReady;

  for (genvar k = 0; k < numStages; k++) begin : gStage
    isqrtStage #(
      .stageIdx(k)
    ) uStage (
      .clk   (clk),
      .arstN (arstN),
      .en    (en),
      .busIn (stageBus[k]),
      .busOut(stageBus[k+1])
    );
  end

  // Output register. The radicand and partial square are dropped here.
  // With en high the slot either was empty or is being read this cycle,
  // so loading it never overwrites an undelivered result.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      outMag   <= '0;
    end else if (en) begin
      outValid <= stageBus[numStages].valid;
      outMag   <= stageBus[numStages].root;
    end
  end

endmodule

//--- magnitudeTop.sv
`timescale 1ns/100ps

module magnitudeTop (
  input  logic           clk,
  input  logic           arstN,
  input  logic           inValid,
  input  isqrtPkg::compT inX,
  input  isqrtPkg::compT inY,
  output logic           inReady,
  output logic           outValid,
  output isqrtPkg::rootT outMag,
  input  logic           outReady
);

  import isqrtPkg::*;

  // Radicand bus from the squarer into the first root stage.
  stageBusT frontBus;

  // The pipe enable doubles as the input ready, so an item is taken
  // exactly on the cycles where the front register loads.
  sumSquares uFront (
    .clk    (clk),
    .arstN  (arstN),
    .en     (inReady),
    .inValid(inValid),
    .inX    (inX),
    .inY    (inY),
    .busOut (frontBus)
  );

  isqrtPipe uPipe (
    .clk     (clk),
    .arstN   (arstN),
    .busIn   (frontBus),
    .en      (inReady),
    .outValid(outValid),
    .outMag  (outMag),
    .outReady(outReady)
  );

endmodule

//--- magnitude_asserts.sv
`timescale 1ns/100ps

module magnitudeAsserts (
  input logic           clk,
  input logic           arstN,
  input logic           inReady,
  input logic           outValid,
  input isqrtPkg::rootT outMag,
  input logic           outReady
);

  import isqrtPkg::*;

  // Reset must empty the output slot.
  resetClearsOutput: assert property (@(posedge clk) !arstN |-> !outValid)
    else $error("outValid high while reset is asserted");

  // A refused result has to wait in place until the consumer takes it.
  // A reset that arrives during the stall releases the check.
  stallHoldsResult: assert property (
    @(posedge clk) arstN && outValid && !outReady |=>
      !arstN || (outValid && $stable(outMag))
  ) else $error("output changed while the consumer was stalling");

  // The input side is ready exactly when the pipe is not stalled.
  readyFollowsStall: assert property (
    @(posedge clk) inReady == !(outValid && !outReady)
  ) else $error("inReady does not match the output stall state");

endmodule

bind magnitudeTop magnitudeAsserts uAsserts (
  .clk     (clk),
  .arstN   (arstN),
  .inReady (inReady),
  .outValid(outValid),
  .outMag  (outMag),
  .outReady(outReady)
);

//--- tbMagnitude.sv
`timescale 1ns/100ps

module tbMagnitude;

  import isqrtPkg::*;

  localparam int pipeLatency = numStages + 2;   // Front end, root stages, output register.
  localparam int acceptTimeout = 200;
  localparam int drainTimeout = 2000;

  logic clk;
  logic arstN;
  logic inValid;
  compT inX;
  compT inY;
  logic inReady;
  logic outValid;
  rootT outMag;
  logic outReady;

  int seed = 32'h37c5;
  int readySeed = 32'h37c5;
  logic [31:0] readyRnd;
  bit readyRandom;

  // Expected results and their acceptance timing, oldest first.
  rootT   expQ[$];
  longint acceptEdgeQ[$];
  longint stallAtAcceptQ[$];

  longint cycleCount;
  longint stallCount;
  int     acceptedCount;
  int     deliveredCount;
  int     droppedCount;
  logic   stalledLast;
  rootT   heldMag;

  magnitudeTop dut (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .inX     (inX),
    .inY     (inY),
    .inReady (inReady),
    .outValid(outValid),
    .outMag  (outMag),
    .outReady(outReady)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // Consumer side. In random mode it accepts on about half the cycles.
  always @(posedge clk) begin
    if (readyRandom) begin
      readyRnd = $random(readySeed);
      outReady <= readyRnd[0];
    end else begin
      outReady <= 1'b1;
    end
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic reportMismatch(input string msg);
    abortRun($sformatf("ERR %0t: %s", $time, msg));
  endtask

  // Floor of the square root of x*x + y*y, found by testing each root bit
  // from the top with a full multiply.
  function automatic rootT refMagnitude(input compT x, input compT y);
    longint          sx;
    longint          sy;
    longint unsigned rad;
    longint unsigned cand;
    rootT            root;
    sx   = x;
    sy   = y;
    rad  = longint'(sx * sx + sy * sy);
    root = '0;
    for (int b = rootW - 1; b >= 0; b--) begin
      cand = longint'(root) | (64'd1 << b);
      if (cand * cand <= rad) begin
        root[b] = 1'b1;
      end
    end
    return root;
  endfunction

  // Presents one vector and returns on the edge that accepts it.
  task automatic sendItem(input int x, input int y);
    int   waitCycles;
    logic taken;
    inValid <= 1'b1;
    inX     <= compT'(x);
    inY     <= compT'(y);
    waitCycles = 0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = inReady;
      @(posedge clk);
      waitCycles++;
      if (!taken && waitCycles >= acceptTimeout) begin
        abortRun($sformatf("input was not accepted within %0d cycles", acceptTimeout));
      end
    end
  endtask

  task automatic sendRandom();
    int x;
    int y;
    x = $random(seed);
    y = $random(seed);
    sendItem(x, y);
  endtask

  task automatic idleCycles(input int n);
    inValid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic applyReset();
    arstN   <= 1'b0;
    inValid <= 1'b0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
  endtask

  // Waits until the output has stayed empty for longer than the pipe latency,
  // so no accepted item can still be inside.
  task automatic waitDrain();
    int waitCycles;
    int quietCycles;
    inValid <= 1'b0;
    readyRandom = 1'b0;
    waitCycles = 0;
    quietCycles = 0;
    while (quietCycles <= pipeLatency) begin
      @(negedge clk);
      quietCycles = outValid ? 0 : quietCycles + 1;
      waitCycles++;
      if (waitCycles >= drainTimeout) begin
        abortRun($sformatf("pipeline did not drain within %0d cycles", drainTimeout));
      end
    end
    @(posedge clk);
  endtask

  task automatic checkCounts(input string phase);
    assert (acceptedCount == deliveredCount + droppedCount)
      else abortRun($sformatf("%s: %0d accepted but %0d delivered and %0d dropped by reset",
                              phase, acceptedCount, deliveredCount, droppedCount));
  endtask

  // Comparing process. At the falling edge all signals are settled and show
  // what the next rising edge will see.
  always @(negedge clk) begin : compareResults
    rootT   expMag;
    longint acceptEdge;
    longint stallsThen;
    longint nextEdge;
    nextEdge = cycleCount + 1;
    if (!arstN) begin
      assert (!outValid) else abortRun("outValid is high while reset is asserted");
      droppedCount += expQ.size();          // In-flight items are lost by design.
      expQ.delete();
      acceptEdgeQ.delete();
      stallAtAcceptQ.delete();
      stalledLast = 1'b0;
    end else begin
      if (stalledLast) begin
        assert (outValid && outMag == heldMag)
          else reportMismatch($sformatf("result changed during a stall, %0d became %0d",
                                        heldMag, outMag));
      end
      if (outValid) begin
        assert (expQ.size() != 0) else abortRun("outValid is high with no input in flight");
        if (outReady) begin
          expMag     = expQ.pop_front();
          acceptEdge = acceptEdgeQ.pop_front();
          stallsThen = stallAtAcceptQ.pop_front();
          assert (outMag == expMag)
            else reportMismatch($sformatf("magnitude %0d, expected %0d", outMag, expMag));
          // Every stall cycle in between adds one cycle to the latency.
          assert (nextEdge - acceptEdge == pipeLatency + stallCount - stallsThen)
            else reportMismatch($sformatf("latency %0d cycles, expected %0d",
                                          nextEdge - acceptEdge,
                                          pipeLatency + stallCount - stallsThen));
          deliveredCount++;
        end
      end
      if (inValid && inReady) begin
        expQ.push_back(refMagnitude(inX, inY));
        acceptEdgeQ.push_back(nextEdge);
        stallAtAcceptQ.push_back(stallCount);
        acceptedCount++;
      end
      if (outValid && !outReady) begin
        stallCount++;
      end
      stalledLast = outValid && !outReady;
      heldMag = outMag;
    end
  end

  initial begin
    logic [31:0] gapRnd;
    clk            = 1'b0;
    arstN          = 1'b0;
    inValid        = 1'b0;
    inX            = '0;
    inY            = '0;
    outReady       = 1'b0;
    readyRandom    = 1'b0;
    cycleCount     = 0;
    stallCount     = 0;
    acceptedCount  = 0;
    deliveredCount = 0;
    droppedCount   = 0;
    stalledLast    = 1'b0;
    heldMag        = '0;

    // Known roots, so the model itself is trusted before it judges the DUT.
    assert (refMagnitude(3, 4) == 5) else abortRun("reference model is wrong for (3, 4)");
    assert (refMagnitude(8, 4) == 8) else abortRun("reference model is wrong for (8, 4)");
    assert (refMagnitude(12, 12) == 16) else abortRun("reference model is wrong for (12, 12)");
    assert (refMagnitude(-8388608, 0) == 8388608)
      else abortRun("reference model is wrong for (-2**23, 0)");

    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);

    // Corner values.
    sendItem(0, 0);
    sendItem(1, 0);
    sendItem(-1, 0);
    sendItem(0, 1);
    sendItem(0, -1);
    sendItem(-8388608, -8388608);
    sendItem(-8388608, 8388607);
    sendItem(8388607, -8388608);
    sendItem(8388607, 8388607);
    sendItem(-8388608, 0);
    sendItem(3, 4);
    sendItem(-3, -4);
    sendItem(5, 12);
    sendItem(2, 2);                          // Radicand 8, one below 9.
    sendItem(8, -4);                         // Radicand 80, one below 81.
    sendItem(12, 12);                        // Radicand 288, one below 289.
    waitDrain();
    checkCounts("corner values");

    // Back-to-back stream with the consumer always ready.
    for (int i = 0; i < 2000; i++) begin
      sendRandom();
    end
    waitDrain();
    checkCounts("streaming");

    readyRandom = 1'b1;
    for (int i = 0; i < 1000; i++) begin
      sendRandom();
    end
    waitDrain();
    checkCounts("back-pressure");

    // Sparse input, a gap of one to eight cycles before about a quarter of the items.
    readyRandom = 1'b1;
    for (int i = 0; i < 500; i++) begin
      gapRnd = $random(seed);
      if (gapRnd[1:0] == 2'b00) begin
        idleCycles(1 + gapRnd[4:2]);
      end
      sendRandom();
    end
    waitDrain();
    checkCounts("sparse input");

    // Reset lands while items are in flight and the consumer stalls.
    readyRandom = 1'b1;
    for (int i = 0; i < 300; i++) begin
      sendRandom();
    end
    applyReset();
    idleCycles(20);
    for (int i = 0; i < 300; i++) begin
      sendRandom();
    end
    waitDrain();

    if (expQ.size() == 0 && acceptedCount == deliveredCount + droppedCount) begin
      $display("sim passed");
      $finish;
    end else begin
      abortRun($sformatf("%0d accepted, %0d delivered, %0d dropped by reset",
                         acceptedCount, deliveredCount, droppedCount));
    end
  end

endmodule

//--- verilog.f
isqrtPkg.sv
sumSquares.sv
isqrtStage.sv
isqrtPipe.sv
magnitudeTop.sv
magnitude_asserts.sv
tbMagnitude.sv

//--- Makefile
TOP = tbMagnitude

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
